// File: filelist.f
hdl/bt_hdr_pkg.sv
hdl/bt_bit_tick.sv
hdl/bt_hec_whiten.sv
hdl/bt_hdr_tx.sv
hdl/bt_hdr_rx.sv
hdl/bt_wb_regs.sv
hdl/bt_hdr_top.sv
tb/tb_clkgen.sv
tb/bt_hdr_checker.sv
tb/bt_hdr_asserts.sv
tb/tb_bt_hdr.sv

// File: hdl/bt_bit_tick.sv
`timescale 1ns/100ps
`default_nettype none

module bt_bit_tick (
  input  logic clk_6M,
  input  logic rstz,
  output logic bit_tick
);
  logic [2:0] div_cnt;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      div_cnt <= 3'd0;
    else if (div_cnt == 3'd5)
      div_cnt <= 3'd0;
    else
      div_cnt <= div_cnt + 3'd1;
  end

  assign bit_tick = (div_cnt == 3'd5);

endmodule

`default_nettype wire

// File: hdl/bt_hdr_pkg.sv
`default_nettype none

package bt_hdr_pkg;

  // word addresses on wishbone adr bits 4:2.
  localparam logic [2:0] reg_ctrl    = 3'd0;
  localparam logic [2:0] reg_txhdr   = 3'd1;
  localparam logic [2:0] reg_sync_lo = 3'd2;
  localparam logic [2:0] reg_sync_hi = 3'd3;
  localparam logic [2:0] reg_uap_clk = 3'd4;
  localparam logic [2:0] reg_status  = 3'd5;
  localparam logic [2:0] reg_rxhdr   = 3'd6;
  localparam logic [2:0] reg_mylt    = 3'd7;

  localparam int hdr_bits = 10;
  localparam int hec_bits = 8;

  localparam logic [3:0] pkt_type_poll = 4'd1;

  // six states, so three bits.
  typedef enum logic [2:0] {
    tx_idle, tx_preamble, tx_sync, tx_trailer, tx_header, tx_hec
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_idle, rx_header, rx_hec, rx_check
  } rx_state_e;

endpackage

`default_nettype wire

// File: hdl/bt_hdr_rx.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hdr_rx #(
  parameter int fec_rep = 3
) (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            bit_tick,
  input  logic                            rx_trailer_end,
  input  logic                            rxbit,
  input  logic [7:0]                      uap,
  input  logic [5:0]                      clk_bits,
  input  logic                            whiten_en,
  input  logic [2:0]                      my_lt,
  output logic                            rx_done,
  output logic [bt_hdr_pkg::hdr_bits-1:0] rx_hdr,
  output logic                            hec_good,
  output logic                            lt_addressed,
  output logic                            rx_is_poll
);
  localparam int rep_w  = (fec_rep > 1) ? $clog2(fec_rep) : 1;
  localparam int ones_w = $clog2(fec_rep + 1);

  bt_hdr_pkg::rx_state_e state;

  logic [3:0]                      bit_cnt;
  logic [rep_w-1:0]                rep_cnt;
  logic [ones_w-1:0]               ones;
  logic [ones_w-1:0]               ones_sum;
  logic                            rep_last;
  logic                            voted;
  logic                            plain_bit;
  logic                            group_end;
  logic                            start;
  logic [bt_hdr_pkg::hec_bits-1:0] hec_rem;
  logic                            white_bit;

  assign start     = bit_tick & rx_trailer_end;
  assign rep_last  = (rep_cnt == rep_w'(fec_rep - 1));
  // majority over the group, current sample included.
  assign ones_sum  = ones + ones_w'(rxbit);
  assign voted     = (ones_sum > ones_w'(fec_rep / 2));
  assign plain_bit = voted ^ white_bit;
  assign group_end = bit_tick & rep_last
                     & ((state == bt_hdr_pkg::rx_header) || (state == bt_hdr_pkg::rx_hec));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state        <= bt_hdr_pkg::rx_idle;
      bit_cnt      <= '0;
      rep_cnt      <= '0;
      ones         <= '0;
      rx_done      <= 1'b0;
      hec_good     <= 1'b0;
      lt_addressed <= 1'b0;
      rx_is_poll   <= 1'b0;
    end
    else if (start)
    begin
      state        <= bt_hdr_pkg::rx_header;
      bit_cnt      <= '0;
      rep_cnt      <= '0;
      ones         <= '0;
      rx_done      <= 1'b0;
      hec_good     <= 1'b0;
      lt_addressed <= 1'b0;
      rx_is_poll   <= 1'b0;
    end
    else if (bit_tick)
    begin
      case (state)
        bt_hdr_pkg::rx_header, bt_hdr_pkg::rx_hec:
        begin
          if (rep_last)
          begin
            rep_cnt <= '0;
            ones    <= '0;
            if (state == bt_hdr_pkg::rx_header && bit_cnt == 4'(bt_hdr_pkg::hdr_bits - 1))
            begin
              state   <= bt_hdr_pkg::rx_hec;
              bit_cnt <= '0;
            end
            else if (state == bt_hdr_pkg::rx_hec && bit_cnt == 4'(bt_hdr_pkg::hec_bits - 1))
            begin
              state   <= bt_hdr_pkg::rx_check;
              bit_cnt <= '0;
            end
            else
              bit_cnt <= bit_cnt + 4'd1;
          end
          else
          begin
            rep_cnt <= rep_cnt + 1'b1;
            ones    <= ones_sum;
          end
        end
        bt_hdr_pkg::rx_check:
        begin
          state        <= bt_hdr_pkg::rx_idle;
          rx_done      <= 1'b1;
          hec_good     <= (hec_rem == '0);
          lt_addressed <= (hec_rem == '0) && (rx_hdr[2:0] == my_lt);
          rx_is_poll   <= (rx_hdr[6:3] == bt_hdr_pkg::pkt_type_poll);
        end
        default: ;
      endcase
    end
  end

  // lsb arrives first.
  always_ff @(posedge clk_6M)
  begin
    if (group_end && !start && state == bt_hdr_pkg::rx_header)
      rx_hdr <= {plain_bit, rx_hdr[bt_hdr_pkg::hdr_bits-1:1]};
  end

  bt_hec_whiten u_hec (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (start),
    .step      (group_end),
    .hec_shift (group_end),
    .data_in   (plain_bit),
    .uap       (uap),
    .clk_bits  (clk_bits),
    .whiten_en (whiten_en),
    .hec_rem   (hec_rem),
    .white_bit (white_bit)
  );

endmodule

`default_nettype wire

// File: hdl/bt_hdr_top.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hdr_top #(
  parameter int fec_rep = 3
) (
  input  logic        clk_6M,
  input  logic        rstz,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [2:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        rxbit,
  input  logic        rx_trailer_end,
  output logic        txbit,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r
);
  logic                            bit_tick;
  logic                            tx_go;
  logic                            whiten_en;
  logic [bt_hdr_pkg::hdr_bits-1:0] tx_hdr;
  logic [63:0]                     sync_word;
  logic [7:0]                      uap;
  logic [5:0]                      clk_bits;
  logic [2:0]                      my_lt;
  logic                            tx_busy;
  logic                            rx_done;
  logic [bt_hdr_pkg::hdr_bits-1:0] rx_hdr;
  logic                            hec_good;
  logic                            lt_addressed;
  logic                            rx_is_poll;

  bt_bit_tick u_bit_tick (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .bit_tick (bit_tick)
  );

  bt_wb_regs u_regs (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .tx_busy      (tx_busy),
    .rx_done      (rx_done),
    .rx_hdr       (rx_hdr),
    .hec_good     (hec_good),
    .lt_addressed (lt_addressed),
    .rx_is_poll   (rx_is_poll),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .tx_go        (tx_go),
    .whiten_en    (whiten_en),
    .tx_hdr       (tx_hdr),
    .sync_word    (sync_word),
    .uap          (uap),
    .clk_bits     (clk_bits),
    .my_lt        (my_lt)
  );

  bt_hdr_tx #(
    .fec_rep (fec_rep)
  ) u_tx (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .bit_tick  (bit_tick),
    .tx_go     (tx_go),
    .tx_hdr    (tx_hdr),
    .sync_word (sync_word),
    .uap       (uap),
    .clk_bits  (clk_bits),
    .whiten_en (whiten_en),
    .txbit     (txbit),
    .tx_busy   (tx_busy)
  );

  bt_hdr_rx #(
    .fec_rep (fec_rep)
  ) u_rx (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .bit_tick       (bit_tick),
    .rx_trailer_end (rx_trailer_end),
    .rxbit          (rxbit),
    .uap            (uap),
    .clk_bits       (clk_bits),
    .whiten_en      (whiten_en),
    .my_lt          (my_lt),
    .rx_done        (rx_done),
    .rx_hdr         (rx_hdr),
    .hec_good       (hec_good),
    .lt_addressed   (lt_addressed),
    .rx_is_poll     (rx_is_poll)
  );

endmodule

`default_nettype wire

// File: hdl/bt_hdr_tx.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hdr_tx #(
  parameter int fec_rep = 3
) (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            bit_tick,
  input  logic                            tx_go,
  input  logic [bt_hdr_pkg::hdr_bits-1:0] tx_hdr,
  input  logic [63:0]                     sync_word,
  input  logic [7:0]                      uap,
  input  logic [5:0]                      clk_bits,
  input  logic                            whiten_en,
  output logic                            txbit,
  output logic                            tx_busy
);
  localparam int rep_w = (fec_rep > 1) ? $clog2(fec_rep) : 1;

  bt_hdr_pkg::tx_state_e state;
  bt_hdr_pkg::tx_state_e next_state;

  logic [5:0]                      bit_cnt;
  logic [rep_w-1:0]                rep_cnt;
  logic                            rep_last;
  logic                            bit_last;
  logic                            coded_phase;
  logic                            data_bit;
  logic                            hec_load;
  logic                            hec_step;
  logic [bt_hdr_pkg::hec_bits-1:0] hec_rem;
  logic                            white_bit;

  assign coded_phase = (state == bt_hdr_pkg::tx_header) || (state == bt_hdr_pkg::tx_hec);
  assign rep_last    = (rep_cnt == rep_w'(fec_rep - 1));
  assign hec_load    = bit_tick & (state == bt_hdr_pkg::tx_trailer) & bit_last;
  assign hec_step    = bit_tick & coded_phase & rep_last;

  always_comb
  begin
    bit_last   = 1'b0;
    data_bit   = 1'b0;
    txbit      = 1'b0;
    next_state = state;
    case (state)
      bt_hdr_pkg::tx_preamble:
      begin
        txbit      = ~sync_word[0] ^ bit_cnt[0];
        bit_last   = (bit_cnt == 6'd3);
        next_state = bt_hdr_pkg::tx_sync;
      end
      bt_hdr_pkg::tx_sync:
      begin
        txbit      = sync_word[bit_cnt];
        bit_last   = (bit_cnt == 6'd63);
        next_state = bt_hdr_pkg::tx_trailer;
      end
      bt_hdr_pkg::tx_trailer:
      begin
        txbit      = ~sync_word[63] ^ bit_cnt[0];
        bit_last   = (bit_cnt == 6'd3);
        next_state = bt_hdr_pkg::tx_header;
      end
      bt_hdr_pkg::tx_header:
      begin
        data_bit   = tx_hdr[bit_cnt[3:0]];
        txbit      = data_bit ^ white_bit;
        bit_last   = rep_last && (bit_cnt == 6'(bt_hdr_pkg::hdr_bits - 1));
        next_state = bt_hdr_pkg::tx_hec;
      end
      bt_hdr_pkg::tx_hec:
      begin
        // msb out first, shifting it back in clears the feedback.
        data_bit   = hec_rem[bt_hdr_pkg::hec_bits-1];
        txbit      = data_bit ^ white_bit;
        bit_last   = rep_last && (bit_cnt == 6'(bt_hdr_pkg::hec_bits - 1));
        next_state = bt_hdr_pkg::tx_idle;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state   <= bt_hdr_pkg::tx_idle;
      bit_cnt <= '0;
      rep_cnt <= '0;
      tx_busy <= 1'b0;
    end
    else
    begin
      if (tx_go && !tx_busy)
        tx_busy <= 1'b1;
      if (bit_tick)
      begin
        if (state == bt_hdr_pkg::tx_idle)
        begin
          if (tx_busy)
            state <= bt_hdr_pkg::tx_preamble;
          bit_cnt <= '0;
          rep_cnt <= '0;
        end
        else
        begin
          if (coded_phase)
            rep_cnt <= rep_last ? '0 : rep_cnt + 1'b1;
          if (bit_last)
          begin
            bit_cnt <= '0;
            state   <= next_state;
            if (state == bt_hdr_pkg::tx_hec)
              tx_busy <= 1'b0;
          end
          else if (!coded_phase || rep_last)
            bit_cnt <= bit_cnt + 6'd1;
        end
      end
    end
  end

  bt_hec_whiten u_hec (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (hec_load),
    .step      (hec_step),
    .hec_shift (hec_step),
    .data_in   (data_bit),
    .uap       (uap),
    .clk_bits  (clk_bits),
    .whiten_en (whiten_en),
    .hec_rem   (hec_rem),
    .white_bit (white_bit)
  );

endmodule

`default_nettype wire

// File: hdl/bt_hec_whiten.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hec_whiten (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            load,
  input  logic                            step,
  input  logic                            hec_shift,
  input  logic                            data_in,
  input  logic [7:0]                      uap,
  input  logic [5:0]                      clk_bits,
  input  logic                            whiten_en,
  output logic [bt_hdr_pkg::hec_bits-1:0] hec_rem,
  output logic                            white_bit
);
  // x^8 term is implied by the feedback.
  localparam logic [bt_hdr_pkg::hec_bits-1:0] hec_poly = 8'ha7;

  logic [6:0] wht;
  logic       hec_fb;
  logic       wht_fb;

  assign hec_fb = data_in ^ hec_rem[bt_hdr_pkg::hec_bits-1];
  assign wht_fb = wht[6];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hec_rem <= '0;
    else if (load)
      hec_rem <= uap;
    else if (hec_shift)
      hec_rem <= {hec_rem[bt_hdr_pkg::hec_bits-2:0], 1'b0}
                 ^ ({bt_hdr_pkg::hec_bits{hec_fb}} & hec_poly);
  end

  // x^7 + x^4 + 1, seeded with 1 and clk 6:1.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wht <= 7'd0;
    else if (load)
      wht <= {1'b1, clk_bits};
    else if (step)
      wht <= {wht[5:0], wht_fb} ^ {2'b00, wht_fb, 4'b0000};
  end

  assign white_bit = whiten_en & wht[6];

endmodule

`default_nettype wire

// File: hdl/bt_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module bt_wb_regs (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            wb_cyc,
  input  logic                            wb_stb,
  input  logic                            wb_we,
  input  logic [2:0]                      wb_adr,
  input  logic [31:0]                     wb_dat_w,
  input  logic                            tx_busy,
  input  logic                            rx_done,
  input  logic [bt_hdr_pkg::hdr_bits-1:0] rx_hdr,
  input  logic                            hec_good,
  input  logic                            lt_addressed,
  input  logic                            rx_is_poll,
  output logic                            wb_ack,
  output logic [31:0]                     wb_dat_r,
  output logic                            tx_go,
  output logic                            whiten_en,
  output logic [bt_hdr_pkg::hdr_bits-1:0] tx_hdr,
  output logic [63:0]                     sync_word,
  output logic [7:0]                      uap,
  output logic [5:0]                      clk_bits,
  output logic [2:0]                      my_lt
);
  logic req;
  logic wr_en;

  // no ack in the cycle after an ack, so each request gets one.
  assign req   = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en = req & wb_we;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      wb_ack <= 1'b0;
      tx_go  <= 1'b0;
    end
    else
    begin
      wb_ack <= req;
      tx_go  <= wr_en && (wb_adr == bt_hdr_pkg::reg_ctrl) && wb_dat_w[0];
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      whiten_en <= 1'b0;
      tx_hdr    <= '0;
      sync_word <= 64'd0;
      uap       <= 8'd0;
      clk_bits  <= 6'd0;
      my_lt     <= 3'd0;
    end
    else if (wr_en)
    begin
      case (wb_adr)
        bt_hdr_pkg::reg_ctrl:    whiten_en <= wb_dat_w[1];
        bt_hdr_pkg::reg_txhdr:   tx_hdr <= wb_dat_w[bt_hdr_pkg::hdr_bits-1:0];
        bt_hdr_pkg::reg_sync_lo: sync_word[31:0] <= wb_dat_w;
        bt_hdr_pkg::reg_sync_hi: sync_word[63:32] <= wb_dat_w;
        bt_hdr_pkg::reg_uap_clk:
        begin
          uap      <= wb_dat_w[7:0];
          clk_bits <= wb_dat_w[13:8];
        end
        bt_hdr_pkg::reg_mylt:    my_lt <= wb_dat_w[2:0];
        default: ;
      endcase
    end
  end

  // start bit reads back as 0.
  always_comb
  begin
    wb_dat_r = 32'd0;
    case (wb_adr)
      bt_hdr_pkg::reg_ctrl:    wb_dat_r[1] = whiten_en;
      bt_hdr_pkg::reg_txhdr:   wb_dat_r[bt_hdr_pkg::hdr_bits-1:0] = tx_hdr;
      bt_hdr_pkg::reg_sync_lo: wb_dat_r = sync_word[31:0];
      bt_hdr_pkg::reg_sync_hi: wb_dat_r = sync_word[63:32];
      bt_hdr_pkg::reg_uap_clk: wb_dat_r[13:0] = {clk_bits, uap};
      bt_hdr_pkg::reg_status:
        wb_dat_r[4:0] = {rx_is_poll, lt_addressed, hec_good, rx_done, tx_busy};
      bt_hdr_pkg::reg_rxhdr:   wb_dat_r[bt_hdr_pkg::hdr_bits-1:0] = rx_hdr;
      bt_hdr_pkg::reg_mylt:    wb_dat_r[2:0] = my_lt;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_bt_hdr \
  -f filelist.f -o sim_tb_bt_hdr &&
./obj_dir/sim_tb_bt_hdr | tee /dev/stderr | grep -q "^test passed$" &&
echo "simulation ok" ||
{
  echo "simulation not ok"
  exit 1
}

// File: tb/bt_hdr_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hdr_asserts (
  input wire logic                  clk_6M,
  input wire logic                  rstz,
  input wire logic                  bit_tick,
  input wire logic                  tx_go,
  input wire logic                  tx_busy,
  input wire logic                  txbit,
  input wire bt_hdr_pkg::tx_state_e state
);
  busy_needs_go: assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(tx_busy) |-> $past(tx_go))
    else $error("tx_busy rose without tx_go");

  idle_is_quiet: assert property (@(posedge clk_6M) disable iff (!rstz)
    !tx_busy |-> (state == bt_hdr_pkg::tx_idle) && !txbit)
    else $error("tx state or txbit active while tx_busy is low");

  state_on_tick: assert property (@(posedge clk_6M) disable iff (!rstz)
    (state != $past(state)) |-> $past(bit_tick))
    else $error("tx state moved without bit_tick");

endmodule

bind bt_hdr_tx bt_hdr_asserts u_asserts (
  .clk_6M   (clk_6M),
  .rstz     (rstz),
  .bit_tick (bit_tick),
  .tx_go    (tx_go),
  .tx_busy  (tx_busy),
  .txbit    (txbit),
  .state    (state)
);

`default_nettype wire

// File: tb/bt_hdr_checker.sv
`timescale 1ns/100ps
`default_nettype none

module bt_hdr_checker (
  input wire logic clk_6M,
  input wire logic txbit,
  input wire logic bit_tick,
  input wire logic tx_active
);
  logic [125:0] cap;
  int           cap_n;
  logic         armed;
  int           phase;
  int           checks;
  int           errors;
  int           tests;
  int           errors_at_start;

  initial
  begin
    cap_n = 0;
    armed = 1'b0;
    phase = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    errors_at_start = 0;
  end

  always @(posedge clk_6M)
  begin
    if (bit_tick)
      phase <= 0;
    else
      phase <= phase + 1;
  end

  // mid-bit sample, three cycles into each bit.
  always @(negedge clk_6M)
  begin
    if (armed && tx_active && phase == 2 && cap_n < 126)
    begin
      cap[cap_n] = txbit;
      cap_n = cap_n + 1;
    end
  end

  task automatic arm_capture();
    cap_n = 0;
    cap = '0;
    armed = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_stream(input logic [125:0] exp);
    checks = checks + 1;
    if (cap_n != 126)
    begin
      errors = errors + 1;
      $display("only %0d of 126 transmit bits were captured", cap_n);
    end
    else if (cap !== exp)
    begin
      errors = errors + 1;
      $display("Error txbit: got 0x%h, expected 0x%h", cap, exp);
    end
  endtask

  task automatic note_failure(input string what);
    errors = errors + 1;
    $display("%s", what);
  endtask

  task automatic finish_test(input string name);
    tests = tests + 1;
    if (errors == errors_at_start)
      $display("%s: ok", name);
    else
      $display("%s: %0d mismatches", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  task automatic report();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

endmodule

`default_nettype wire

// File: tb/tb_bt_hdr.sv
`timescale 1ns/100ps
`default_nettype none

module tb_bt_hdr;
  localparam int n_tx    = 8;
  localparam int n_rx    = 8;
  localparam int n_bad   = 2;
  localparam int limit   = (n_tx + n_rx + n_bad + 1 + 1) * 126 * 6 + 20000;

  logic        clk_6M;
  logic        rstz;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        rxbit;
  logic        rx_trailer_end;
  logic        txbit;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  logic        bit_tick;
  logic        tx_active;
  int          seed;

  tb_clkgen u_clkgen (
    .clk_6M (clk_6M),
    .rstz   (rstz)
  );

  bt_hdr_top #(
    .fec_rep (3)
  ) u_bt_hdr_top (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .rxbit          (rxbit),
    .rx_trailer_end (rx_trailer_end),
    .txbit          (txbit),
    .wb_ack         (wb_ack),
    .wb_dat_r       (wb_dat_r)
  );

  assign bit_tick  = u_bt_hdr_top.bit_tick;
  assign tx_active = (u_bt_hdr_top.u_tx.state != bt_hdr_pkg::tx_idle);

  bt_hdr_checker u_checker (
    .clk_6M    (clk_6M),
    .txbit     (txbit),
    .bit_tick  (bit_tick),
    .tx_active (tx_active)
  );

  initial
  begin
    repeat (limit) @(posedge clk_6M);
    $display("timeout after %0d cycles, the run did not finish", limit);
    $display("test failed");
    $finish;
  end

  // access code, then header and hec, whitened and sent three times each.
  task automatic build_stream(input logic [9:0] hdr, input logic [63:0] sw,
                              input logic [7:0] u, input logic [5:0] ck,
                              input logic wen, output logic [125:0] s);
    logic [7:0]  hec;
    logic [6:0]  lfsr;
    logic [17:0] data;
    logic        fb;
    logic        w;
    int          n;
    n = 0;
    for (int i = 0; i < 4; i++)
    begin
      s[n] = ~sw[0] ^ i[0];
      n++;
    end
    for (int i = 0; i < 64; i++)
    begin
      s[n] = sw[i];
      n++;
    end
    for (int i = 0; i < 4; i++)
    begin
      s[n] = ~sw[63] ^ i[0];
      n++;
    end
    hec = u;
    for (int i = 0; i < 10; i++)
    begin
      fb = hdr[i] ^ hec[7];
      hec = {hec[6:0], 1'b0} ^ (fb ? 8'ha7 : 8'h00);
    end
    data[9:0] = hdr;
    for (int k = 0; k < 8; k++)
      data[10 + k] = hec[7 - k];
    lfsr = {1'b1, ck};
    for (int j = 0; j < 18; j++)
    begin
      w = wen & lfsr[6];
      for (int r = 0; r < 3; r++)
      begin
        s[n] = data[j] ^ w;
        n++;
      end
      fb = lfsr[6];
      lfsr = {lfsr[5:0], fb} ^ {2'b00, fb, 4'b0000};
    end
  endtask

  task automatic wb_xfer(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int waits;
    waits = 0;
    @(negedge clk_6M);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdat;
    do
    begin
      @(negedge clk_6M);
      waits++;
    end
    while (!wb_ack && waits < 16);
    if (!wb_ack)
      u_checker.note_failure("wishbone ack never arrived");
    rdat = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdat);
    wb_xfer(1'b0, adr, 32'd0, rdat);
  endtask

  task automatic configure(input logic [9:0] hdr, input logic [63:0] sw,
                           input logic [7:0] u, input logic [5:0] ck, input logic wen);
    wb_write(bt_hdr_pkg::reg_txhdr, {22'd0, hdr});
    wb_write(bt_hdr_pkg::reg_sync_lo, sw[31:0]);
    wb_write(bt_hdr_pkg::reg_sync_hi, sw[63:32]);
    wb_write(bt_hdr_pkg::reg_uap_clk, {18'd0, ck, u});
    wb_write(bt_hdr_pkg::reg_ctrl, {30'd0, wen, 1'b0});
  endtask

  task automatic wait_capture();
    int waits;
    waits = 0;
    while (u_checker.cap_n < 126 && waits < 126 * 6 + 100)
    begin
      @(negedge clk_6M);
      waits++;
    end
  endtask

  task automatic wait_tx_idle();
    int waits;
    waits = 0;
    while (tx_active && waits < 126 * 6 + 100)
    begin
      @(negedge clk_6M);
      waits++;
    end
    if (tx_active)
      u_checker.note_failure("transmitter did not return to idle");
  endtask

  task automatic wait_tick_negedge();
    do
      @(negedge clk_6M);
    while (!bit_tick);
  endtask

  task automatic feed_rx(input logic [53:0] bits);
    wait_tick_negedge();
    rx_trailer_end = 1'b1;
    for (int i = 0; i < 54; i++)
    begin
      wait_tick_negedge();
      rx_trailer_end = 1'b0;
      rxbit = bits[i];
    end
    wait_tick_negedge();
    rxbit = 1'b0;
  endtask

  task automatic wait_rx_done(output logic [31:0] status);
    int polls;
    polls = 0;
    wb_read(bt_hdr_pkg::reg_status, status);
    while (!status[1] && polls < 100)
    begin
      wb_read(bt_hdr_pkg::reg_status, status);
      polls++;
    end
    if (!status[1])
      u_checker.note_failure("rx_done never came after the header");
  endtask

  function automatic logic [9:0] pack_hdr(input logic [2:0] lt, input logic [3:0] typ,
                                          input logic [2:0] fas);
    return {fas, typ, lt};
  endfunction

  initial
  begin : main
    logic [31:0]  rd;
    logic [31:0]  wd;
    logic [9:0]   hdr;
    logic [63:0]  sw;
    logic [7:0]   u;
    logic [5:0]   ck;
    logic         wen;
    logic [2:0]   lt;
    logic [2:0]   my_lt;
    logic [3:0]   typ;
    logic [125:0] s;
    logic [53:0]  coded;
    int           idx;
    int           skip;

    seed = 32'haced;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 3'd0;
    wb_dat_w = 32'd0;
    rxbit = 1'b0;
    rx_trailer_end = 1'b0;
    wait (rstz === 1'b1);

    wb_read(bt_hdr_pkg::reg_status, rd);
    u_checker.check_value("status", rd, 32'd0);
    repeat (40)
    begin
      @(negedge clk_6M);
      u_checker.check_value("txbit", {31'd0, txbit}, 32'd0);
    end
    u_checker.finish_test("reset_state");

    // registers read back only their defined bits.
    repeat (4)
    begin
      wd = $random(seed);
      wb_write(bt_hdr_pkg::reg_txhdr, wd);
      wb_read(bt_hdr_pkg::reg_txhdr, rd);
      u_checker.check_value("reg_txhdr", rd, wd & 32'h3ff);
      wd = $random(seed);
      wb_write(bt_hdr_pkg::reg_sync_lo, wd);
      wb_read(bt_hdr_pkg::reg_sync_lo, rd);
      u_checker.check_value("reg_sync_lo", rd, wd);
      wd = $random(seed);
      wb_write(bt_hdr_pkg::reg_sync_hi, wd);
      wb_read(bt_hdr_pkg::reg_sync_hi, rd);
      u_checker.check_value("reg_sync_hi", rd, wd);
      wd = $random(seed);
      wb_write(bt_hdr_pkg::reg_uap_clk, wd);
      wb_read(bt_hdr_pkg::reg_uap_clk, rd);
      u_checker.check_value("reg_uap_clk", rd, wd & 32'h3fff);
      wd = $random(seed);
      wb_write(bt_hdr_pkg::reg_mylt, wd);
      wb_read(bt_hdr_pkg::reg_mylt, rd);
      u_checker.check_value("reg_mylt", rd, wd & 32'h7);
    end
    u_checker.finish_test("register_access");

    for (int k = 0; k < n_tx; k++)
    begin
      hdr = $random(seed);
      sw = {$random(seed), $random(seed)};
      u = $random(seed);
      ck = $random(seed);
      wen = k[0];
      configure(hdr, sw, u, ck, wen);
      build_stream(hdr, sw, u, ck, wen, s);
      u_checker.arm_capture();
      wb_write(bt_hdr_pkg::reg_ctrl, {30'd0, wen, 1'b1});
      wait_capture();
      u_checker.check_stream(s);
      wait_tx_idle();
      wb_read(bt_hdr_pkg::reg_status, rd);
      u_checker.check_value("tx_busy", rd & 32'h1, 32'd0);
    end
    u_checker.finish_test("tx_stream");

    my_lt = $random(seed);
    wb_write(bt_hdr_pkg::reg_mylt, {29'd0, my_lt});
    for (int k = 0; k < n_rx; k++)
    begin
      lt = (k % 2 == 0) ? my_lt : 3'($random(seed));
      typ = (k % 3 == 0) ? 4'd1 : 4'($random(seed));
      hdr = pack_hdr(lt, typ, 3'($random(seed)));
      u = $random(seed);
      ck = $random(seed);
      wen = ~k[0];
      configure(hdr, 64'd0, u, ck, wen);
      build_stream(hdr, 64'd0, u, ck, wen, s);
      coded = s[125:72];
      // a single wrong sample per triple is outvoted.
      for (int j = 0; j < 18; j++)
      begin
        if ($random(seed) & 1)
        begin
          idx = ($random(seed) & 32'h7fffffff) % 3;
          coded[3 * j + idx] = ~coded[3 * j + idx];
        end
      end
      feed_rx(coded);
      wait_rx_done(rd);
      u_checker.check_value("status", rd & 32'h1f,
                            {27'd0, typ == 4'd1, lt == my_lt, 1'b1, 1'b1, 1'b0});
      wb_read(bt_hdr_pkg::reg_rxhdr, rd);
      u_checker.check_value("reg_rxhdr", rd, {22'd0, hdr});
    end
    u_checker.finish_test("rx_single_errors");

    for (int k = 0; k < n_bad; k++)
    begin
      hdr = pack_hdr(my_lt, 4'($random(seed)), 3'($random(seed)));
      u = $random(seed);
      ck = $random(seed);
      wen = 1'b1;
      configure(hdr, 64'd0, u, ck, wen);
      build_stream(hdr, 64'd0, u, ck, wen, s);
      coded = s[125:72];
      idx = ($random(seed) & 32'h7fffffff) % 18;
      skip = ($random(seed) & 32'h7fffffff) % 3;
      for (int r = 0; r < 3; r++)
      begin
        if (r != skip)
          coded[3 * idx + r] = ~coded[3 * idx + r];
      end
      feed_rx(coded);
      wait_rx_done(rd);
      u_checker.check_value("status", rd & 32'he, 32'h2);
    end
    u_checker.finish_test("rx_double_error");

    hdr = $random(seed);
    sw = {$random(seed), $random(seed)};
    u = $random(seed);
    ck = $random(seed);
    configure(hdr, sw, u, ck, 1'b1);
    build_stream(hdr, sw, u, ck, 1'b1, s);
    u_checker.arm_capture();
    wb_write(bt_hdr_pkg::reg_ctrl, 32'h3);
    while (u_checker.cap_n < 20)
      @(negedge clk_6M);
    wb_write(bt_hdr_pkg::reg_ctrl, 32'h3);
    wait_capture();
    u_checker.check_stream(s);
    wait_tx_idle();
    wb_read(bt_hdr_pkg::reg_status, rd);
    u_checker.check_value("tx_busy", rd & 32'h1, 32'd0);
    repeat (60)
    begin
      @(negedge clk_6M);
      u_checker.check_value("tx_active", {31'd0, tx_active}, 32'd0);
    end
    u_checker.finish_test("tx_go_while_busy");

    u_checker.report();
    if (u_checker.errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk_6M,
  output logic rstz
);
  initial
  begin
    clk_6M = 1'b0;
    forever #5 clk_6M = ~clk_6M;
  end

  initial
  begin
    rstz = 1'b0;
    repeat (16) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
  end

endmodule

`default_nettype wire
